// ==== src/bus_map_pkg.sv ====
package bus_map_pkg;

    //////////////////////////////////////////////////
    // Z80 bus as seen by the controller
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [15:0] a;         // Address bus
        logic [7:0]  d;         // Data bus from CPU
        logic        rd_n;
        logic        wr_n;
        logic        mreq_n;    // Memory request
        logic        iorq_n;    // IO request
    } bus_in_t;

    // One-hot IO port decode
    typedef struct packed {
        logic [3:0] bank;       // One bit per bank register
        logic       sysctrl;
        logic       cassette;
        logic       printer;
        logic       keyboard;
    } io_sel_t;

    //////////////////////////////////////////////////
    // IO port map
    //////////////////////////////////////////////////

    localparam logic [7:0] IO_BANK0    = 8'hF0;
    localparam logic [7:0] IO_BANK1    = 8'hF1;
    localparam logic [7:0] IO_BANK2    = 8'hF2;
    localparam logic [7:0] IO_BANK3    = 8'hF3;
    localparam logic [7:0] IO_SYSCTRL  = 8'hFB;
    localparam logic [7:0] IO_CASSETTE = 8'hFC;
    localparam logic [7:0] IO_PRINTER  = 8'hFE;
    localparam logic [7:0] IO_KEYBOARD = 8'hFF;

    //////////////////////////////////////////////////
    // Memory map
    //////////////////////////////////////////////////

    localparam logic [2:0] SYSRAM_BLOCK = 3'd7;  // 3800-3FFF inside a 16 KB window
    localparam logic [1:0] ROM_PAGE_TOP = 2'd0;  // Pages 0-15
    localparam logic [4:0] SYSRAM_BA    = 5'd0;  // Bank address of system RAM

endpackage

// ==== src/sys_regs_pkg.sv ====
package sys_regs_pkg;

    //////////////////////////////////////////////////
    // Bank registers
    //////////////////////////////////////////////////

    // Field view used by the address decode
    typedef struct packed {
        logic       ro;         // Write protect
        logic       overlay;    // System RAM overlay at 3800
        logic [5:0] page;       // 16 KB page number
    } bank_fields_t;

    // CPU sees a raw byte, decode sees the fields
    typedef union packed {
        logic [7:0]   raw;
        bank_fields_t f;
    } bank_reg_u;

    typedef bank_reg_u [3:0] bank_regs_t;

    // Power-up mapping
    localparam logic [7:0] BANK0_RESET = 8'hC0;  // Overlay, read only, page 0
    localparam logic [7:0] BANK1_RESET = 8'h21;  // Page 33
    localparam logic [7:0] BANK2_RESET = 8'h22;  // Page 34
    localparam logic [7:0] BANK3_RESET = 8'h13;  // Page 19

    //////////////////////////////////////////////////
    // System control register
    //////////////////////////////////////////////////

    // Hides the bank registers from the IO space
    localparam int SYSCTRL_DIS_REGS_BIT = 0;

endpackage

// ==== src/bus_sync.sv ====
`timescale 1ns/1ps

module bus_sync (
    input  logic       sysclk,
    input  logic       reset,
    input  logic       wr_n,
    input  logic [7:0] d,
    output logic       wr_pulse,
    output logic [7:0] wrdata
);

    logic [2:0] wr_n_r;     // Strobe history with bit 0 newest

    // Three flop chain that idles high
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_n_r <= 3'b111;
        end else begin
            wr_n_r <= {wr_n_r[1:0], wr_n};
        end
    end

    // Falling edge seen between the two older stages
    assign wr_pulse = wr_n_r[2] && !wr_n_r[1];

    // Data byte follows the bus while the strobe is low
    always_ff @(posedge sysclk) begin
        if (!wr_n) begin
            wrdata <= d;
        end
    end

endmodule

// ==== src/addr_decode.sv ====
`timescale 1ns/1ps

module addr_decode (
    input  bus_map_pkg::bus_in_t    bus,
    input  sys_regs_pkg::bank_regs_t banks,
    input  logic                     dis_regs,
    output bus_map_pkg::io_sel_t    io_sel,
    output logic                     io_hit,
    output logic [4:0]               ba,
    output logic                     ram_ce_n,
    output logic                     ram_we_n
);

    sys_regs_pkg::bank_reg_u bank;  // Bank register for this access

    logic [7:0] port;               // Low address byte in IO cycles
    logic       io_cycle;
    logic       sel_sysram;
    logic       allow_mem;
    logic       sel_ram;
    logic       sel_rom;

    //////////////////////////////////////////////////
    // Memory space
    //////////////////////////////////////////////////

    // Upper two address bits pick one of four 16 KB windows
    assign bank = banks[bus.a[15:14]];

    assign sel_sysram = !bus.mreq_n && bank.f.overlay &&
                        (bus.a[13:11] == bus_map_pkg::SYSRAM_BLOCK);

    // Writes to read-only pages are not passed to the memory
    assign allow_mem = !bus.mreq_n && !sel_sysram && (bus.wr_n || !bank.f.ro);

    assign sel_ram = (allow_mem && bank.f.page[5]) || sel_sysram;  // Pages 32-63
    assign sel_rom = allow_mem && (bank.f.page[5:4] == bus_map_pkg::ROM_PAGE_TOP);

    assign ram_ce_n = !sel_ram;

    // ROM pages live in the same RAM and can be written when not protected
    assign ram_we_n = !(!bus.wr_n &&
                        (sel_sysram || ((sel_ram || sel_rom) && !bank.f.ro)));

    // System RAM always sits at the bottom of the RAM
    assign ba = sel_sysram ? bus_map_pkg::SYSRAM_BA : bank.f.page[4:0];

    //////////////////////////////////////////////////
    // IO space
    //////////////////////////////////////////////////

    assign port     = bus.a[7:0];
    assign io_cycle = !bus.iorq_n;

    always_comb begin
        io_sel = '0;

        // Bank registers can be hidden from the CPU
        if (io_cycle && !dis_regs) begin
            io_sel.bank[0] = (port == bus_map_pkg::IO_BANK0);
            io_sel.bank[1] = (port == bus_map_pkg::IO_BANK1);
            io_sel.bank[2] = (port == bus_map_pkg::IO_BANK2);
            io_sel.bank[3] = (port == bus_map_pkg::IO_BANK3);
        end

        if (io_cycle) begin
            io_sel.sysctrl  = (port == bus_map_pkg::IO_SYSCTRL);
            io_sel.cassette = (port == bus_map_pkg::IO_CASSETTE);
            io_sel.printer  = (port == bus_map_pkg::IO_PRINTER);
            io_sel.keyboard = (port == bus_map_pkg::IO_KEYBOARD);
        end
    end

    assign io_hit = |io_sel;    // Any internal port claims the cycle

endmodule

// ==== src/io_regs.sv ====
`timescale 1ns/1ps

module io_regs (
    input  logic                     sysclk,
    input  logic                     reset,
    input  bus_map_pkg::io_sel_t    io_sel,
    input  logic                     wr_pulse,
    input  logic [7:0]               wrdata,
    output sys_regs_pkg::bank_regs_t banks,
    output logic                     dis_regs,
    output logic                     cassette_out,
    output logic                     printer_out
);

    sys_regs_pkg::bank_regs_t banks_q;

    logic dis_regs_q;
    logic cassette_q;
    logic printer_q;

    //////////////////////////////////////////////////
    // Bank registers
    //////////////////////////////////////////////////

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            banks_q[0].raw <= sys_regs_pkg::BANK0_RESET;
            banks_q[1].raw <= sys_regs_pkg::BANK1_RESET;
            banks_q[2].raw <= sys_regs_pkg::BANK2_RESET;
            banks_q[3].raw <= sys_regs_pkg::BANK3_RESET;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (io_sel.bank[i] && wr_pulse) begin
                    banks_q[i].raw <= wrdata;   // Whole byte so the fields come along
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Single-bit latches
    //////////////////////////////////////////////////

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            dis_regs_q <= 1'b0;
            cassette_q <= 1'b0;
            printer_q  <= 1'b0;
        end else if (wr_pulse) begin
            if (io_sel.sysctrl) begin
                dis_regs_q <= wrdata[sys_regs_pkg::SYSCTRL_DIS_REGS_BIT];
            end
            if (io_sel.cassette) begin
                cassette_q <= wrdata[0];    // Tape output
            end
            if (io_sel.printer) begin
                printer_q <= wrdata[0];
            end
        end
    end

    assign banks        = banks_q;
    assign dis_regs     = dis_regs_q;
    assign cassette_out = cassette_q;
    assign printer_out  = printer_q;

endmodule

// ==== src/read_mux.sv ====
`timescale 1ns/1ps

module read_mux (
    input  bus_map_pkg::bus_in_t    bus,
    input  bus_map_pkg::io_sel_t    io_sel,
    input  logic                     io_hit,
    input  sys_regs_pkg::bank_regs_t banks,
    input  logic                     dis_regs,
    input  logic                     cassette_in,
    input  logic                     printer_in,
    input  logic [63:0]              keys,
    output logic [7:0]               d_out,
    output logic                     d_oe
);

    logic [7:0] kbd_data;
    logic [7:0] sysctrl_data;
    logic [7:0] rddata;

    //////////////////////////////////////////////////
    // Keyboard matrix
    //////////////////////////////////////////////////

    // Low bits of the upper address byte select rows and pressed keys read as 0
    always_comb begin
        kbd_data = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!bus.a[8 + row]) begin
                kbd_data &= keys[8*row +: 8];
            end
        end
    end

    //////////////////////////////////////////////////
    // Read data
    //////////////////////////////////////////////////

    always_comb begin
        sysctrl_data = 8'h00;
        sysctrl_data[sys_regs_pkg::SYSCTRL_DIS_REGS_BIT] = dis_regs;
    end

    // Selects are one-hot so order does not matter
    always_comb begin
        rddata = 8'h00;
        for (int i = 0; i < 4; i++) begin
            if (io_sel.bank[i]) begin
                rddata = banks[i].raw;
            end
        end
        if (io_sel.sysctrl) begin
            rddata = sysctrl_data;
        end
        if (io_sel.cassette) begin
            rddata = {7'b0, cassette_in};
        end
        if (io_sel.printer) begin
            rddata = {7'b0, printer_in};
        end
        if (io_sel.keyboard) begin
            rddata = kbd_data;
        end
    end

    assign d_out = rddata;
    assign d_oe  = !bus.rd_n && io_hit;     // Drive the bus only for our own ports

endmodule

// ==== src/bus_ctrl.sv ====
`timescale 1ns/1ps

module bus_ctrl (
    input  logic                 sysclk,
    input  logic                 reset,
    input  bus_map_pkg::bus_in_t bus,
    input  logic                 cassette_in,
    input  logic                 printer_in,
    input  logic [63:0]          keys,
    output logic [7:0]           d_out,
    output logic                 d_oe,
    output logic [4:0]           ba,
    output logic                 ram_ce_n,
    output logic                 ram_we_n,
    output logic                 cassette_out,
    output logic                 printer_out
);

    logic                     wr_pulse;
    logic [7:0]               wrdata;
    sys_regs_pkg::bank_regs_t banks;
    logic                     dis_regs;
    bus_map_pkg::io_sel_t     io_sel;
    logic                     io_hit;

    //////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////

    bus_sync bus_sync_inst (
        .sysclk   (sysclk),
        .reset    (reset),
        .wr_n     (bus.wr_n),
        .d        (bus.d),
        .wr_pulse (wr_pulse),
        .wrdata   (wrdata)
    );

    //////////////////////////////////////////////////
    // Decode and registers
    //////////////////////////////////////////////////

    addr_decode addr_decode_inst (
        .bus      (bus),
        .banks    (banks),
        .dis_regs (dis_regs),
        .io_sel   (io_sel),
        .io_hit   (io_hit),
        .ba       (ba),         // RAM controls go straight out
        .ram_ce_n (ram_ce_n),
        .ram_we_n (ram_we_n)
    );

    io_regs io_regs_inst (
        .sysclk       (sysclk),
        .reset        (reset),
        .io_sel       (io_sel),
        .wr_pulse     (wr_pulse),
        .wrdata       (wrdata),
        .banks        (banks),
        .dis_regs     (dis_regs),
        .cassette_out (cassette_out),
        .printer_out  (printer_out)
    );

    //////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////

    read_mux read_mux_inst (
        .bus         (bus),
        .io_sel      (io_sel),
        .io_hit      (io_hit),
        .banks       (banks),
        .dis_regs    (dis_regs),
        .cassette_in (cassette_in),
        .printer_in  (printer_in),
        .keys        (keys),
        .d_out       (d_out),
        .d_oe        (d_oe)
    );

endmodule

// ==== tests/bus_ctrl_props.sv ====
`timescale 1ns/1ps

module bus_ctrl_props (
    input logic                 sysclk,
    input logic                 reset,
    input bus_map_pkg::bus_in_t bus,
    input logic                 d_oe,
    input logic                 ram_ce_n,
    input logic                 ram_we_n,
    input logic                 wr_pulse
);

    // Data goes back to the CPU only in a read cycle
    a_doe_needs_read: assert property (@(posedge sysclk) disable iff (reset)
        d_oe |-> !bus.rd_n)
        else $error("d_oe high while rd_n is high");

    a_ce_needs_mreq: assert property (@(posedge sysclk) disable iff (reset)
        !ram_ce_n |-> !bus.mreq_n)
        else $error("ram_ce_n low outside a memory request");

    a_we_needs_wr: assert property (@(posedge sysclk) disable iff (reset)
        !ram_we_n |-> !bus.wr_n)
        else $error("ram_we_n low while wr_n is high");

    // One pulse per strobe edge
    a_pulse_single: assert property (@(posedge sysclk) disable iff (reset)
        wr_pulse |=> !wr_pulse)
        else $error("wr_pulse high for two cycles");

endmodule

bind bus_ctrl bus_ctrl_props bus_ctrl_props_inst (
    .sysclk   (sysclk),
    .reset    (reset),
    .bus      (bus),
    .d_oe     (d_oe),
    .ram_ce_n (ram_ce_n),
    .ram_we_n (ram_we_n),
    .wr_pulse (wr_pulse)
);

// ==== tests/tb_bus_ctrl.sv ====
`timescale 1ns/1ps

module tb_bus_ctrl;

    localparam int WRITE_LEN   = 8;
    localparam int READ_LEN    = 3;
    localparam int BANK_ROUNDS = 8;
    localparam int MEM_GROUPS  = 8;
    localparam int MEM_OPS     = 25;
    localparam int PORT_ROUNDS = 16;
    localparam int KBD_READS   = 32;
    // Memory accesses counted at write length
    localparam int TEST_CYCLES = 2 + 5 * READ_LEN
        + BANK_ROUNDS * 4 * (WRITE_LEN + READ_LEN) + READ_LEN
        + 6 * WRITE_LEN + 9 * READ_LEN
        + MEM_GROUPS * (4 + MEM_OPS) * WRITE_LEN
        + PORT_ROUNDS * 2 * (WRITE_LEN + READ_LEN)
        + KBD_READS * READ_LEN;
    localparam int CYCLE_LIMIT = TEST_CYCLES * 3 / 2;

    typedef struct packed {
        logic [4:0] ba;
        logic       ce_n;
        logic       we_n;
    } mem_resp_t;

    logic                 sysclk;
    logic                 reset;
    bus_map_pkg::bus_in_t bus;
    logic                 cassette_in;
    logic                 printer_in;
    logic [63:0]          keys;
    logic [7:0]           d_out;
    logic                 d_oe;
    logic [4:0]           ba;
    logic                 ram_ce_n;
    logic                 ram_we_n;
    logic                 cassette_out;
    logic                 printer_out;

    logic [31:0] seed = 32'hcef7_57aa;
    int          cycle_count = 0;
    logic [7:0]  model_bank [4];    // Reference copy of the registers
    logic        model_dis;
    logic        model_cas;
    logic        model_prn;
    logic        cas_val;           // Input values for the next read
    logic        prn_val;
    logic [63:0] key_val;

    bus_ctrl bus_ctrl_inst (
        .sysclk       (sysclk),
        .reset        (reset),
        .bus          (bus),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .keys         (keys),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .ba           (ba),
        .ram_ce_n     (ram_ce_n),
        .ram_we_n     (ram_we_n),
        .cassette_out (cassette_out),
        .printer_out  (printer_out)
    );

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "Run stopped by the cycle counter");
        end
    end

    //////////////////////////////////////////////////
    // Random numbers and reference model

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        seed = xorshift(seed);
        return seed;
    endfunction

    task automatic model_write(input logic [7:0] port, input logic [7:0] data);
        case (port)
            8'hF0, 8'hF1, 8'hF2, 8'hF3: begin
                if (!model_dis) begin
                    model_bank[port[1:0]] = data;
                end
            end
            8'hFB: model_dis = data[0];
            8'hFC: model_cas = data[0];
            8'hFE: model_prn = data[0];
            default: ;
        endcase
    endtask

    // Rows with a low address bit are ANDed in
    function automatic logic [7:0] kbd_expect(input logic [7:0] upper, input logic [63:0] k);
        logic [7:0] v;
        v = 8'hFF;
        for (int r = 0; r < 8; r++) begin
            if (upper[r] == 1'b0) begin
                v = v & k[r*8 +: 8];
            end
        end
        return v;
    endfunction

    function automatic logic [8:0] io_expect(input logic [15:0] addr);    // {d_oe, d_out}
        case (addr[7:0])
            8'hF0, 8'hF1, 8'hF2, 8'hF3:
                return model_dis ? 9'h000 : {1'b1, model_bank[addr[1:0]]};
            8'hFB:   return {1'b1, 7'b0, model_dis};
            8'hFC:   return {1'b1, 7'b0, cas_val};
            8'hFE:   return {1'b1, 7'b0, prn_val};
            8'hFF:   return {1'b1, kbd_expect(addr[15:8], key_val)};
            default: return 9'h000;
        endcase
    endfunction

    function automatic mem_resp_t mem_expect(input logic [15:0] addr, input logic is_write);
        logic [7:0] b;
        logic       sysram;
        logic       allowed;
        logic       ram;
        logic       rom;
        mem_resp_t  r;
        b       = model_bank[addr[15:14]];
        sysram  = b[6] && (addr[13:11] == 3'b111);    // Overlay block 3800-3FFF
        allowed = !sysram && !(is_write && b[7]);
        ram     = (allowed && b[5]) || sysram;
        rom     = allowed && (b[5:4] == 2'b00);
        r.ba    = sysram ? 5'd0 : b[4:0];
        r.ce_n  = !ram;
        r.we_n  = !(is_write && (sysram || ((ram || rom) && !b[7])));
        return r;
    endfunction

    //////////////////////////////////////////////////
    // Bus cycles and checks

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        if (got !== expected) begin
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge sysclk);
        bus.a      <= addr;
        bus.d      <= data;
        bus.iorq_n <= 1'b0;
        bus.wr_n   <= 1'b0;
        repeat (6) @(posedge sysclk);
        bus.iorq_n <= 1'b1;
        bus.wr_n   <= 1'b1;
        @(posedge sysclk);
        @(negedge sysclk);
        model_write(addr[7:0], data);
    endtask

    task automatic io_read(input logic [15:0] addr);
        logic [8:0] exp_rd;
        exp_rd = io_expect(addr);
        @(posedge sysclk);
        bus.a       <= addr;
        bus.iorq_n  <= 1'b0;
        bus.rd_n    <= 1'b0;
        cassette_in <= cas_val;
        printer_in  <= prn_val;
        keys        <= key_val;
        @(posedge sysclk);
        @(negedge sysclk);
        check_value("d_oe", d_oe, exp_rd[8]);
        check_value("d_out", d_out, exp_rd[7:0]);
        @(posedge sysclk);
        bus.iorq_n <= 1'b1;
        bus.rd_n   <= 1'b1;
        @(negedge sysclk);
    endtask

    task automatic read_banks();
        for (int i = 0; i < 4; i++) begin
            io_read(16'h00F0 + 16'(i));
        end
    endtask

    task automatic mem_access(input logic [15:0] addr, input logic is_write,
                              input logic [7:0] data);
        mem_resp_t exp_mem;
        exp_mem = mem_expect(addr, is_write);
        @(posedge sysclk);
        bus.a      <= addr;
        bus.d      <= data;
        bus.mreq_n <= 1'b0;
        bus.wr_n   <= !is_write;
        bus.rd_n   <= is_write;
        @(posedge sysclk);
        @(negedge sysclk);
        check_value("ba", ba, exp_mem.ba);
        check_value("ram_ce_n", ram_ce_n, exp_mem.ce_n);
        check_value("ram_we_n", ram_we_n, exp_mem.we_n);
        check_value("d_oe", d_oe, 1'b0);
        repeat (is_write ? 5 : 1) @(posedge sysclk);    // Writes keep the strobe for 6 cycles
        bus.mreq_n <= 1'b1;
        bus.wr_n   <= 1'b1;
        bus.rd_n   <= 1'b1;
        if (is_write) begin
            @(posedge sysclk);
        end
        @(negedge sysclk);
    endtask

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] r;
        logic [15:0] addr;
        reset = 1'b1;
        bus   = '{a: 16'h0000, d: 8'h00, rd_n: 1'b1, wr_n: 1'b1, mreq_n: 1'b1, iorq_n: 1'b1};
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        keys        = '1;
        cas_val     = 1'b0;
        prn_val     = 1'b0;
        key_val     = '1;
        model_bank  = '{8'hC0, 8'h21, 8'h22, 8'h13};
        model_dis   = 1'b0;
        model_cas   = 1'b0;
        model_prn   = 1'b0;
        repeat (2) @(posedge sysclk);
        reset <= 1'b0;
        @(negedge sysclk);

        read_banks();                   // Power-up values
        io_read(16'h00FB);
        check_value("cassette_out", cassette_out, 1'b0);
        check_value("printer_out", printer_out, 1'b0);

        for (int n = 0; n < BANK_ROUNDS; n++) begin
            for (int i = 0; i < 4; i++) begin
                r = next_random();
                io_write(16'h00F0 + 16'(i), r[7:0]);
            end
            read_banks();
        end
        io_read(16'h00FD);              // Unmapped port

        io_write(16'h00FB, 8'h01);      // Hide the bank registers
        io_read(16'h00FB);
        read_banks();
        for (int i = 0; i < 4; i++) begin
            r = next_random();
            io_write(16'h00F0 + 16'(i), r[7:0]);
        end
        io_write(16'h00FB, 8'h00);
        read_banks();

        for (int g = 0; g < MEM_GROUPS; g++) begin
            for (int i = 0; i < 4; i++) begin
                r = next_random();
                io_write(16'h00F0 + 16'(i), r[7:0]);
            end
            for (int n = 0; n < MEM_OPS; n++) begin
                r    = next_random();
                addr = r[15:0];
                if (r[17:16] == 2'b00) begin
                    addr[13:11] = 3'b111;   // Aim at the overlay block more often
                end
                mem_access(addr, r[18], r[26:19]);
            end
        end

        for (int n = 0; n < PORT_ROUNDS; n++) begin
            r = next_random();
            io_write(16'h00FC, r[7:0]);
            check_value("cassette_out", cassette_out, model_cas);
            io_write(16'h00FE, r[15:8]);
            check_value("printer_out", printer_out, model_prn);
            cas_val = r[16];
            prn_val = r[17];
            io_read(16'h00FC);
            io_read(16'h00FE);
        end

        for (int n = 0; n < KBD_READS; n++) begin
            key_val = {next_random(), next_random()} | {next_random(), next_random()};
            r = next_random();
            io_read({r[7:0], 8'hFF});
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== build.f ====
src/bus_map_pkg.sv
src/sys_regs_pkg.sv
src/bus_sync.sv
src/addr_decode.sv
src/io_regs.sv
src/read_mux.sv
src/bus_ctrl.sv
tests/bus_ctrl_props.sv
tests/tb_bus_ctrl.sv

// ==== Makefile ====
TOP := tb_bus_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): build.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -o V$(TOP)

test: obj_dir/V$(TOP)
	-obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then \
		echo "Result: failed"; exit 1; \
	fi
	@echo "Result: passed"

clean:
	rm -rf obj_dir sim.log
